// ==== verilog/dl_rx_pkg.sv ====
// data link receive package
// widths, CRC constants, DLLP type bytes and the packed stream types
// shared by the receive path

package dl_rx_pkg;

  // stream and sequence widths
  localparam int DATA_W = 32;
  localparam int SEQ_W  = 12;

  // frame FIFO geometry
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW    = 6;

  // reflected CRC-32 for the LCRC
  localparam logic [31:0] LCRC_INIT = 32'hFFFF_FFFF;
  localparam logic [31:0] LCRC_POLY = 32'hEDB8_8320;

  // reflected CRC-16 for the DLLP CRC
  localparam logic [15:0] DCRC_INIT = 16'hFFFF;
  localparam logic [15:0] DCRC_POLY = 16'hD008;

  // DLLP type bytes
  localparam logic [7:0] DLLP_ACK = 8'h00;
  localparam logic [7:0] DLLP_NAK = 8'h10;

  // one beat of the receive stream
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } rx_beat_t;

  // outcome of one received frame
  typedef struct packed {
    logic             nak;
    logic [SEQ_W-1:0] seq;
  } verdict_t;

  // Ack/Nak DLLP toward the physical layer
  typedef struct packed {
    logic             nak;
    logic [SEQ_W-1:0] seq;
    logic [15:0]      crc;
  } ack_dllp_t;

endpackage

// ==== verilog/skid_buffer.sv ====
// skid buffer
// two-entry valid/ready register slice, breaks the ready path
// while keeping full throughput

module skid_buffer #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     s_data_i,
  input  logic s_valid_i,
  output logic s_ready_o,
  output T     m_data_o,
  output logic m_valid_o,
  input  logic m_ready_i
);

  T     m_data_q;
  T     skid_data_q;
  logic m_valid_q;
  logic skid_valid_q;
  logic ready_q;
  logic load_out;
  logic s_xfer;

  // output register may take new data
  assign load_out = m_ready_i || !m_valid_q;
  assign s_xfer   = s_valid_i && ready_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_valid_q    <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (load_out) begin
        if (skid_valid_q) begin
          // drain the skid entry first
          m_valid_q    <= 1'b1;
          skid_valid_q <= 1'b0;
        end else begin
          m_valid_q <= s_xfer;
        end
      end else if (s_xfer) begin
        // output stalled, park the beat
        skid_valid_q <= 1'b1;
        ready_q      <= 1'b0;
      end else begin
        ready_q <= !skid_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_out) begin
      m_data_q <= skid_valid_q ? skid_data_q : s_data_i;
    end
    if (ready_q) begin
      skid_data_q <= s_data_i;
    end
  end

  assign s_ready_o = ready_q;
  assign m_data_o  = m_data_q;
  assign m_valid_o = m_valid_q;

  // a stalled output beat is held until taken
  a_out_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o));

endmodule

// ==== verilog/crc32_byte_step.sv ====
// CRC-32 byte step
// reflected CRC-32 update over one byte, LSB first

module crc32_byte_step (
  input  logic [31:0] crc_i,
  input  logic [7:0]  byte_i,
  output logic [31:0] crc_o
);

  logic [31:0] crc_v;

  // eight serial shifts of the reflected register
  always_comb begin
    crc_v = crc_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_v[0] ^ byte_i[i]) begin
        crc_v = (crc_v >> 1) ^ dl_rx_pkg::LCRC_POLY;
      end else begin
        crc_v = crc_v >> 1;
      end
    end
    crc_o = crc_v;
  end

endmodule

// ==== verilog/lcrc_checker.sv ====
// LCRC checker
// running CRC-32 over the two sequence bytes and every TLP dword,
// compared against the LCRC beat

module lcrc_checker (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  logic        word_en_i,
  input  logic [31:0] word_i,
  input  logic [31:0] lcrc_i,
  output logic        match_o
);

  logic [31:0] crc_q;
  logic [31:0] chain [5];

  // start of frame restarts from the seed
  assign chain[0] = start_i ? dl_rx_pkg::LCRC_INIT : crc_q;

  // byte 0 through byte 3 in order
  for (genvar i = 0; i < 4; i++) begin : g_step
    crc32_byte_step u_step (
      .crc_i  (chain[i]),
      .byte_i (word_i[8*i +: 8]),
      .crc_o  (chain[i+1])
    );
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= dl_rx_pkg::LCRC_INIT;
    end else if (start_i) begin
      // sequence beat covers bytes 0 and 1 only
      crc_q <= chain[2];
    end else if (word_en_i) begin
      crc_q <= chain[4];
    end
  end

  // transmitted LCRC is the inverted remainder
  assign match_o = (~crc_q == lcrc_i);

  a_start_word_excl : assert property (@(posedge clk_i) disable iff (rst_i)
    !(start_i && word_en_i));

endmodule

// ==== verilog/tlp_rx_ctrl.sv ====
// TLP receive controller
// parses sequence, TLP and LCRC beats, writes TLP words one beat late
// into the frame FIFO and decides commit/drop and Ack/Nak per frame

module tlp_rx_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                link_up_i,
  input  dl_rx_pkg::rx_beat_t beat_i,
  input  logic                beat_valid_i,
  output logic                beat_ready_o,
  output logic                fifo_wr_o,
  output dl_rx_pkg::rx_beat_t fifo_data_o,
  input  logic                fifo_space_i,
  output logic                commit_o,
  output logic                drop_o,
  output dl_rx_pkg::verdict_t verdict_o,
  output logic                verdict_valid_o,
  input  logic                verdict_ready_i
);

  typedef enum logic [1:0] {
    ST_SEQ,
    ST_FIRST,
    ST_STREAM,
    ST_VERDICT
  } state_e;

  state_e                        state_q;
  logic [dl_rx_pkg::SEQ_W-1:0]   exp_q;
  logic [dl_rx_pkg::SEQ_W-1:0]   exp_prev;
  logic [dl_rx_pkg::SEQ_W-1:0]   exp_next;
  logic [dl_rx_pkg::SEQ_W-1:0]   seq_q;
  logic                          seq_bad_q;
  logic [dl_rx_pkg::DATA_W-1:0]  held_q;
  dl_rx_pkg::verdict_t           verdict_q;
  logic                          xfer;
  logic                          frame_end;
  logic                          crc_match;
  logic                          crc_ok;
  logic                          good_new;
  logic                          dup;

  assign beat_ready_o = link_up_i && fifo_space_i && (state_q != ST_VERDICT);
  assign xfer         = beat_valid_i && beat_ready_o;
  assign frame_end    = xfer && (state_q == ST_STREAM) && beat_i.last;

  lcrc_checker u_lcrc (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (xfer && (state_q == ST_SEQ)),
    .word_en_i (xfer && !beat_i.last && (state_q inside {ST_FIRST, ST_STREAM})),
    .word_i    (beat_i.data),
    .lcrc_i    (beat_i.data),
    .match_o   (crc_match)
  );

  // sequence rule
  assign crc_ok   = crc_match && !seq_bad_q;
  assign exp_prev = exp_q - 1'b1;
  assign good_new = crc_ok && (seq_q == exp_q);
  assign dup      = crc_ok && (seq_q == exp_prev);
  assign exp_next = good_new ? exp_q + 1'b1 : exp_q;

  // held word goes out one beat late with last on the LCRC beat
  assign fifo_wr_o        = xfer && (state_q == ST_STREAM);
  assign fifo_data_o.data = held_q;
  assign fifo_data_o.last = beat_i.last;
  assign commit_o         = frame_end && good_new;
  assign drop_o           = frame_end && !good_new;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_SEQ;
      exp_q   <= '0;
    end else begin
      case (state_q)
        ST_SEQ: begin
          if (xfer) state_q <= ST_FIRST;
        end
        ST_FIRST: begin
          if (xfer) state_q <= ST_STREAM;
        end
        ST_STREAM: begin
          if (frame_end) begin
            state_q <= ST_VERDICT;
            exp_q   <= exp_next;
          end
        end
        ST_VERDICT: begin
          if (verdict_ready_i) state_q <= ST_SEQ;
        end
        default: state_q <= ST_SEQ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer && (state_q == ST_SEQ)) begin
      seq_q     <= beat_i.data[dl_rx_pkg::SEQ_W-1:0];
      seq_bad_q <= (beat_i.data[15:12] != 4'h0);
    end
    if (xfer && !beat_i.last) begin
      held_q <= beat_i.data;
    end
    if (frame_end) begin
      // DLLP carries the expected number minus one
      verdict_q.nak <= !(good_new || dup);
      verdict_q.seq <= exp_next - 1'b1;
    end
  end

  assign verdict_o       = verdict_q;
  assign verdict_valid_o = (state_q == ST_VERDICT);

  // a frame holds at least one TLP dword before its LCRC beat
  a_frame_shape : assert property (@(posedge clk_i) disable iff (rst_i)
    xfer && (state_q inside {ST_SEQ, ST_FIRST}) |-> !beat_i.last);

endmodule

// ==== verilog/tlp_frame_fifo.sv ====
// TLP frame FIFO
// circular RAM with a working and a committed write pointer;
// only committed frames are readable, a drop rewinds the frame

module tlp_frame_fifo (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wr_i,
  input  dl_rx_pkg::rx_beat_t wr_data_i,
  output logic                space_o,
  input  logic                commit_i,
  input  logic                drop_i,
  output dl_rx_pkg::rx_beat_t rd_data_o,
  output logic                rd_valid_o,
  input  logic                rd_ready_i
);

  localparam int PW = dl_rx_pkg::FIFO_AW + 1;

  dl_rx_pkg::rx_beat_t mem [dl_rx_pkg::FIFO_DEPTH];

  // pointers carry one wrap bit
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] cm_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_inc;
  logic [PW-1:0] used;
  logic          rd_xfer;

  assign wr_ptr_inc = wr_ptr_q + 1'b1;
  assign used       = wr_ptr_q - rd_ptr_q;
  assign space_o    = (used != PW'(dl_rx_pkg::FIFO_DEPTH));
  assign rd_valid_o = (rd_ptr_q != cm_ptr_q);
  assign rd_xfer    = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem[wr_ptr_q[dl_rx_pkg::FIFO_AW-1:0]] <= wr_data_i;
    end
  end

  assign rd_data_o = mem[rd_ptr_q[dl_rx_pkg::FIFO_AW-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      cm_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (drop_i) begin
        // discard the whole open frame, including this cycle's word
        wr_ptr_q <= cm_ptr_q;
      end else if (wr_i) begin
        wr_ptr_q <= wr_ptr_inc;
      end
      if (commit_i) begin
        cm_ptr_q <= wr_i ? wr_ptr_inc : wr_ptr_q;
      end
      if (rd_xfer) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // the controller must respect the space flag
  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    wr_i |-> space_o);

endmodule

// ==== verilog/ack_dllp_gen.sv ====
// Ack/Nak DLLP builder
// forms the four DLLP bytes from a verdict and appends the
// inverted reflected CRC-16

module ack_dllp_gen (
  input  dl_rx_pkg::verdict_t  verdict_i,
  input  logic                 verdict_valid_i,
  output logic                 verdict_ready_o,
  output dl_rx_pkg::ack_dllp_t dllp_o,
  output logic                 dllp_valid_o,
  input  logic                 dllp_ready_i
);

  logic [7:0]  type_byte;
  logic [31:0] msg;
  logic [15:0] crc_v;

  assign type_byte = verdict_i.nak ? dl_rx_pkg::DLLP_NAK : dl_rx_pkg::DLLP_ACK;

  // byte k sits at msg[8k +: 8], sent in that order
  assign msg = {verdict_i.seq[7:0], {4'h0, verdict_i.seq[11:8]}, 8'h00, type_byte};

  always_comb begin
    crc_v = dl_rx_pkg::DCRC_INIT;
    for (int i = 0; i < 32; i++) begin
      if (crc_v[0] ^ msg[i]) begin
        crc_v = (crc_v >> 1) ^ dl_rx_pkg::DCRC_POLY;
      end else begin
        crc_v = crc_v >> 1;
      end
    end
  end

  assign dllp_o.nak = verdict_i.nak;
  assign dllp_o.seq = verdict_i.seq;
  assign dllp_o.crc = ~crc_v;

  // handshake passes straight through to the output slice
  assign dllp_valid_o    = verdict_valid_i;
  assign verdict_ready_o = dllp_ready_i;

endmodule

// ==== verilog/dllp_rx_top.sv ====
// data link layer receive top
// input slice, frame controller, frame FIFO and Ack/Nak DLLP path

module dllp_rx_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 link_up_i,
  input  dl_rx_pkg::rx_beat_t  s_beat_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  output dl_rx_pkg::rx_beat_t  m_tlp_o,
  output logic                 m_tlp_valid_o,
  input  logic                 m_tlp_ready_i,
  output dl_rx_pkg::ack_dllp_t m_dllp_o,
  output logic                 m_dllp_valid_o,
  input  logic                 m_dllp_ready_i
);

  dl_rx_pkg::rx_beat_t  in_beat;
  logic                 in_valid;
  logic                 in_ready;
  logic                 slice_ready;
  logic                 fifo_wr;
  dl_rx_pkg::rx_beat_t  fifo_data;
  logic                 fifo_space;
  logic                 commit;
  logic                 drop;
  dl_rx_pkg::verdict_t  verdict;
  logic                 verdict_valid;
  logic                 verdict_ready;
  dl_rx_pkg::ack_dllp_t dllp;
  logic                 dllp_valid;
  logic                 dllp_ready;

  // no intake while the link is down
  assign s_ready_o = slice_ready && link_up_i;

  skid_buffer #(.T(dl_rx_pkg::rx_beat_t)) u_in_slice (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_data_i  (s_beat_i),
    .s_valid_i (s_valid_i && link_up_i),
    .s_ready_o (slice_ready),
    .m_data_o  (in_beat),
    .m_valid_o (in_valid),
    .m_ready_i (in_ready)
  );

  tlp_rx_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_up_i       (link_up_i),
    .beat_i          (in_beat),
    .beat_valid_i    (in_valid),
    .beat_ready_o    (in_ready),
    .fifo_wr_o       (fifo_wr),
    .fifo_data_o     (fifo_data),
    .fifo_space_i    (fifo_space),
    .commit_o        (commit),
    .drop_o          (drop),
    .verdict_o       (verdict),
    .verdict_valid_o (verdict_valid),
    .verdict_ready_i (verdict_ready)
  );

  tlp_frame_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_i       (fifo_wr),
    .wr_data_i  (fifo_data),
    .space_o    (fifo_space),
    .commit_i   (commit),
    .drop_i     (drop),
    .rd_data_o  (m_tlp_o),
    .rd_valid_o (m_tlp_valid_o),
    .rd_ready_i (m_tlp_ready_i)
  );

  ack_dllp_gen u_dllp_gen (
    .verdict_i       (verdict),
    .verdict_valid_i (verdict_valid),
    .verdict_ready_o (verdict_ready),
    .dllp_o          (dllp),
    .dllp_valid_o    (dllp_valid),
    .dllp_ready_i    (dllp_ready)
  );

  skid_buffer #(.T(dl_rx_pkg::ack_dllp_t)) u_dllp_slice (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_data_i  (dllp),
    .s_valid_i (dllp_valid),
    .s_ready_o (dllp_ready),
    .m_data_o  (m_dllp_o),
    .m_valid_o (m_dllp_valid_o),
    .m_ready_i (m_dllp_ready_i)
  );

endmodule

// ==== sim/tb_dllp_rx.sv ====
// testbench for the data link receive block
// sends good, bad-CRC, duplicate and out-of-order frames under random
// back-pressure and link-down windows while assertions check both outputs

module tb_dllp_rx;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum int {
    FR_GOOD,
    FR_BAD_CRC,
    FR_DUP,
    FR_OOO
  } frame_kind_e;

  localparam int N_RANDOM = 100;
  localparam int EXP_SIZE = 4096;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 link_up;
  dl_rx_pkg::rx_beat_t  s_beat;
  logic                 s_valid;
  logic                 s_ready;
  dl_rx_pkg::rx_beat_t  m_tlp;
  logic                 m_tlp_valid;
  logic                 m_tlp_ready;
  dl_rx_pkg::ack_dllp_t m_dllp;
  logic                 m_dllp_valid;
  logic                 m_dllp_ready;

  // expected outputs filled ahead of each frame and consumed per transfer
  dl_rx_pkg::rx_beat_t  tlp_exp [EXP_SIZE];
  dl_rx_pkg::ack_dllp_t dllp_exp [EXP_SIZE];
  int tlp_wr = 0;
  int tlp_rd = 0;
  int dllp_wr = 0;
  int dllp_rd = 0;

  logic [11:0] exp_seq = '0;
  int beats_sent = 0;
  int cycles = 0;
  int down_left = 0;
  int tlp_errs = 0;
  int dllp_errs = 0;
  int link_errs = 0;

  always #20 clk = ~clk;

  dllp_rx_top u_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .link_up_i      (link_up),
    .s_beat_i       (s_beat),
    .s_valid_i      (s_valid),
    .s_ready_o      (s_ready),
    .m_tlp_o        (m_tlp),
    .m_tlp_valid_o  (m_tlp_valid),
    .m_tlp_ready_i  (m_tlp_ready),
    .m_dllp_o       (m_dllp),
    .m_dllp_valid_o (m_dllp_valid),
    .m_dllp_ready_i (m_dllp_ready)
  );

  // reflected CRC-32 over one byte LSB first
  function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return c;
  endfunction

  // inverted reflected CRC-16 over type, zero, seq high nibble, seq low byte
  function automatic logic [15:0] dllp_crc(input logic nak, input logic [11:0] seq);
    logic [7:0]  msg [4];
    logic [15:0] c;
    msg[0] = nak ? 8'h10 : 8'h00;
    msg[1] = 8'h00;
    msg[2] = {4'h0, seq[11:8]};
    msg[3] = seq[7:0];
    c = 16'hFFFF;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 8; i++) begin
        c = (c[0] ^ msg[k][i]) ? ((c >> 1) ^ 16'hD008) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  function automatic frame_kind_e pick_kind();
    int r;
    r = $urandom % 8;
    if (r == 5) return FR_BAD_CRC;
    if (r == 6) return FR_DUP;
    if (r == 7) return FR_OOO;
    return FR_GOOD;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("[ERROR] %0t: %s (got %h, expected %h)", $time, what, got, want);
  endtask

  // one clock with the transfer sampled just after the last input change
  task automatic tick(output logic took);
    #1;
    took = s_valid && s_ready;
    @(posedge clk);
    #2;
    if (down_left > 0) begin
      down_left--;
    end else if ($urandom % 60 == 0) begin
      down_left = 1 + $urandom % 8;
    end
    link_up      = (down_left == 0);
    m_tlp_ready  = ($urandom % 4 != 0);
    m_dllp_ready = ($urandom % 3 != 0);
  endtask

  task automatic send_beat(input logic [31:0] data, input logic last);
    logic took;
    while ($urandom % 4 == 0) begin
      tick(took);
    end
    s_beat.data = data;
    s_beat.last = last;
    s_valid     = 1'b1;
    do begin
      tick(took);
    end while (!took);
    s_valid = 1'b0;
    beats_sent++;
  endtask

  task automatic send_frame(input frame_kind_e kind);
    logic [11:0] seq;
    logic [31:0] crc;
    logic [31:0] lcrc;
    logic [31:0] words [16];
    logic        nak;
    int          len;
    len = 1 + $urandom % 16;
    case (kind)
      FR_DUP:  seq = exp_seq - 12'd1;
      FR_OOO:  seq = exp_seq + 12'(1 + $urandom % 4000);
      default: seq = exp_seq;
    endcase
    crc = 32'hFFFF_FFFF;
    crc = crc32_byte(crc, seq[7:0]);
    crc = crc32_byte(crc, {4'h0, seq[11:8]});
    for (int i = 0; i < len; i++) begin
      words[i] = $urandom;
      for (int b = 0; b < 4; b++) begin
        crc = crc32_byte(crc, words[i][8*b +: 8]);
      end
    end
    lcrc = ~crc;
    if (kind == FR_BAD_CRC) begin
      lcrc = lcrc ^ (32'h1 << ($urandom % 32));
    end
    // sequence rule decides what the frame yields
    nak = 1'b1;
    if (lcrc == ~crc && seq == exp_seq) begin
      for (int i = 0; i < len; i++) begin
        tlp_exp[tlp_wr].data = words[i];
        tlp_exp[tlp_wr].last = (i == len - 1);
        tlp_wr++;
      end
      exp_seq = exp_seq + 12'd1;
      nak     = 1'b0;
    end else if (lcrc == ~crc && seq == exp_seq - 12'd1) begin
      nak = 1'b0;
    end
    dllp_exp[dllp_wr].nak = nak;
    dllp_exp[dllp_wr].seq = exp_seq - 12'd1;
    dllp_exp[dllp_wr].crc = dllp_crc(nak, exp_seq - 12'd1);
    dllp_wr++;
    send_beat({16'h0, 4'h0, seq}, 1'b0);
    for (int i = 0; i < len; i++) begin
      send_beat(words[i], 1'b0);
    end
    send_beat(lcrc, 1'b1);
  endtask

  initial begin
    logic took;
    void'($urandom(32'h411cf419));
    rst          = 1'b1;
    link_up      = 1'b0;
    s_valid      = 1'b0;
    s_beat       = '0;
    m_tlp_ready  = 1'b0;
    m_dllp_ready = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst     = 1'b0;
    link_up = 1'b1;
    // directed opening where the first Nak must carry 4095
    send_frame(FR_BAD_CRC);
    send_frame(FR_GOOD);
    send_frame(FR_DUP);
    send_frame(FR_OOO);
    send_frame(FR_GOOD);
    for (int f = 0; f < N_RANDOM; f++) begin
      send_frame(pick_kind());
    end
    while (tlp_rd != tlp_wr || dllp_rd != dllp_wr) begin
      tick(took);
    end
    repeat (20) tick(took);
    $display("errors: tlp %0d, dllp %0d, link %0d", tlp_errs, dllp_errs, link_errs);
    if (tlp_errs + dllp_errs + link_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // advance past each output transfer
  always @(posedge clk) begin
    if (rst) begin
      tlp_rd  <= 0;
      dllp_rd <= 0;
    end else begin
      if (m_tlp_valid && m_tlp_ready) tlp_rd <= tlp_rd + 1;
      if (m_dllp_valid && m_dllp_ready) dllp_rd <= dllp_rd + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 30 * beats_sent + 2000) begin
      $display("timeout after %0d cycles, outputs stopped making progress", cycles);
      $display("Test failed");
      $finish;
    end
  end

  a_tlp_word : assert property (@(posedge clk) disable iff (rst)
    m_tlp_valid && m_tlp_ready |-> tlp_rd < tlp_wr && m_tlp == tlp_exp[tlp_rd])
    else begin
      tlp_errs++;
      report_mismatch("TLP word unexpected or wrong", 64'($sampled(m_tlp)),
                      64'(tlp_exp[$sampled(tlp_rd)]));
    end

  a_dllp : assert property (@(posedge clk) disable iff (rst)
    m_dllp_valid && m_dllp_ready |-> dllp_rd < dllp_wr && m_dllp == dllp_exp[dllp_rd])
    else begin
      dllp_errs++;
      report_mismatch("DLLP unexpected or wrong", 64'($sampled(m_dllp)),
                      64'(dllp_exp[$sampled(dllp_rd)]));
    end

  a_dllp_crc : assert property (@(posedge clk) disable iff (rst)
    m_dllp_valid && m_dllp_ready |-> m_dllp.crc == dllp_crc(m_dllp.nak, m_dllp.seq))
    else begin
      dllp_errs++;
      report_mismatch("DLLP CRC field", 64'($sampled(m_dllp.crc)),
                      64'(dllp_crc($sampled(m_dllp.nak), $sampled(m_dllp.seq))));
    end

  a_link_gate : assert property (@(posedge clk) disable iff (rst)
    s_valid && s_ready |-> link_up)
    else begin
      link_errs++;
      $display("%0t: an input beat was accepted while the link was down", $time);
    end

endmodule

// ==== dllp_rx_top.f ====
verilog/dl_rx_pkg.sv
verilog/skid_buffer.sv
verilog/crc32_byte_step.sv
verilog/lcrc_checker.sv
verilog/tlp_rx_ctrl.sv
verilog/tlp_frame_fifo.sv
verilog/ack_dllp_gen.sv
verilog/dllp_rx_top.sv
sim/tb_dllp_rx.sv

// ==== Makefile ====
# Verilator build and run of the data link receive testbench

SRCS := $(filter-out +%,$(shell cat dllp_rx_top.f))

obj_dir/Vtb_dllp_rx: dllp_rx_top.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
	  --top-module tb_dllp_rx -f dllp_rx_top.f -o Vtb_dllp_rx

run: obj_dir/Vtb_dllp_rx
	-./obj_dir/Vtb_dllp_rx > sim.log 2>&1
	cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
